// File: all.f
+incdir+include
hw/pix_pkg.sv
hw/pix_frame_sync.sv
hw/pix_fifo.sv
hw/pix_controller.sv
hw/frame_store.sv
hw/pix_top.sv
verif/pix_checker.sv
verif/pix_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = pix_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/pix_tb.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module pix_tb;

    // About thirteen commands of up to 700 cycles, doubled for margin
    localparam int CMD_COUNT      = 13;
    localparam int CYCLES_PER_CMD = 700;
    localparam int MAX_CYCLES     = CMD_COUNT * CYCLES_PER_CMD * 2 + 2000;

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            cmd_ready;
    logic                            cmd_trigger;
    pix_pkg::pix_cmd_t               cmd;
    logic [$clog2(`BLOCK_COUNT)-1:0] cmd_block;
    logic                            cmd_abort;
    logic                            readout_ready;
    logic                            readout_trigger = 1'b0;
    logic [`WORD_WIDTH-1:0]          readout_data;
    logic [`PIX_WIDTH-1:0]           pix_d;
    logic                            pix_fv;
    logic                            pix_lv;

    integer seed = 32'h6343;
    int     errors;
    int     reads_done;
    int     expected_reads = 0;
    int     cycles = 0;
    int     blank_left;
    logic   rd_gaps = 1'b0;
    logic [$clog2(`BLOCK_COUNT)-1:0] blk_a;
    logic [$clog2(`BLOCK_COUNT)-1:0] blk_b;
    logic [$clog2(`BLOCK_COUNT)-1:0] blk_c;

    always #2 clk = ~clk;

    pix_top dut_i (
        .clk(clk), .rst(rst),
        .cmd_ready(cmd_ready), .cmd_trigger(cmd_trigger), .cmd(cmd),
        .cmd_block(cmd_block), .cmd_abort(cmd_abort),
        .readout_ready(readout_ready), .readout_trigger(readout_trigger),
        .readout_data(readout_data),
        .pix_d(pix_d), .pix_fv(pix_fv), .pix_lv(pix_lv)
    );

    pix_checker checker_i (
        .clk(clk), .rst(rst),
        .cmd_ready(cmd_ready), .cmd_trigger(cmd_trigger), .cmd(cmd),
        .cmd_block(cmd_block), .cmd_abort(cmd_abort),
        .readout_ready(readout_ready), .readout_trigger(readout_trigger),
        .readout_data(readout_data),
        .pix_d(pix_d), .pix_fv(pix_fv), .pix_lv(pix_lv),
        .errors(errors), .reads_done(reads_done)
    );

    // ==============================
    // Sensor model
    // ==============================
    initial begin
        pix_d      = '0;
        pix_fv     = 1'b0;
        pix_lv     = 1'b0;
        blank_left = 0;
        forever begin
            // Frame blanking
            blank_left = 10 + ($random(seed) & 31);
            while (blank_left > 0) begin
                @(posedge clk);
                pix_fv <= 1'b0;
                pix_lv <= 1'b0;
                blank_left = blank_left - 1;
            end
            for (int line = 0; line < 16; line++) begin
                for (int px = 0; px < 16; px++) begin
                    @(posedge clk);
                    pix_fv <= 1'b1;
                    pix_lv <= 1'b1;
                    pix_d  <= `PIX_WIDTH'($random(seed));
                end
                // Line blanking carries junk data that must not be stored
                repeat (1 + ($random(seed) & 3)) begin
                    @(posedge clk);
                    pix_lv <= 1'b0;
                    pix_d  <= `PIX_WIDTH'($random(seed));
                end
            end
        end
    end

    // Readout consumer, with random gaps when asked
    always @(posedge clk) begin
        if (rst) begin
            readout_trigger <= 1'b0;
        end else begin
            readout_trigger <= rd_gaps ? (($random(seed) & 3) == 0) : 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (!cmd_ready);
    endtask

    // A capture waits until a frame is running or clearly not about to start
    task automatic send_cmd(input pix_pkg::pix_cmd_t c,
                            input logic [$clog2(`BLOCK_COUNT)-1:0] blk,
                            input logic mid_frame);
        logic safe;
        do begin
            @(posedge clk);
            safe = mid_frame ? (pix_fv && pix_lv) : (pix_fv || blank_left > 8);
        end while (!cmd_ready || (c == pix_pkg::CMD_CAPTURE && !safe));
        cmd_trigger <= 1'b1;
        cmd         <= c;
        cmd_block   <= blk;
        @(posedge clk);
        cmd_trigger <= 1'b0;
    endtask

    task automatic capture(input logic [$clog2(`BLOCK_COUNT)-1:0] blk, input logic mid);
        send_cmd(pix_pkg::CMD_CAPTURE, blk, mid);
        wait_idle();
    endtask

    task automatic readout(input logic [$clog2(`BLOCK_COUNT)-1:0] blk, input logic gaps);
        rd_gaps = gaps;
        send_cmd(pix_pkg::CMD_READOUT, blk, 1'b0);
        wait_idle();
        expected_reads++;
    endtask

    task automatic abort_cmd(input pix_pkg::pix_cmd_t c,
                             input logic [$clog2(`BLOCK_COUNT)-1:0] blk, input int delay);
        rd_gaps = 1'b1;
        send_cmd(c, blk, 1'b0);
        repeat (delay) @(posedge clk);
        cmd_abort <= 1'b1;
        @(posedge clk);
        cmd_abort <= 1'b0;
        wait_idle();
    endtask

    // ==============================
    // Command sequence
    // ==============================
    initial begin
        rst         = 1'b1;
        cmd_trigger = 1'b0;
        cmd         = pix_pkg::CMD_CAPTURE;
        cmd_block   = '0;
        cmd_abort   = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wait_idle();

        capture(3'd0, 1'b0);
        readout(3'd0, 1'b0);

        blk_a = 3'($random(seed)) | 3'd1;
        blk_b = blk_a + 3'd2;
        blk_c = blk_a + 3'd4;
        capture(blk_a, 1'b0);
        capture(blk_b, 1'b0);
        capture(blk_c, 1'b1);
        readout(blk_a, 1'b1);
        readout(blk_b, 1'b1);
        readout(blk_c, 1'b0);
        readout(3'd0, 1'b1);

        // Abort a capture into an unused even block, then a readout
        abort_cmd(pix_pkg::CMD_CAPTURE, (blk_a == 3'd7) ? 3'd6 : blk_a + 3'd1,
                  60 + ($random(seed) & 127));
        abort_cmd(pix_pkg::CMD_READOUT, blk_b, 20 + ($random(seed) & 127));
        readout(blk_b, 1'b1);
        readout(3'd0, 1'b0);

        repeat (4) @(posedge clk);
        if (reads_done != expected_reads) begin
            $display("Error: %0d readouts completed, %0d expected", reads_done, expected_reads);
        end
        $display("Errors: %0d", errors);
        if (errors == 0 && reads_done == expected_reads) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/pix_checker.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module pix_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cmd_ready,
    input  logic                             cmd_trigger,
    input  pix_pkg::pix_cmd_t                cmd,
    input  logic [$clog2(`BLOCK_COUNT)-1:0]  cmd_block,
    input  logic                             cmd_abort,
    input  logic                             readout_ready,
    input  logic                             readout_trigger,
    input  logic [`WORD_WIDTH-1:0]           readout_data,
    input  logic [`PIX_WIDTH-1:0]            pix_d,
    input  logic                             pix_fv,
    input  logic                             pix_lv,
    output int                               errors,
    output int                               reads_done
);

    localparam int OFS_W = $clog2(`IMAGE_SIZE);
    localparam int BLK_W = $clog2(`BLOCK_COUNT);

    // Stored frames, rebuilt from the pixel pins
    logic [`PIX_WIDTH-1:0] model [`BLOCK_COUNT][`IMAGE_SIZE];
    logic [`PIX_WIDTH-1:0] frame_buf [`IMAGE_SIZE];
    logic                  block_valid [`BLOCK_COUNT];

    // Capture tracking: 0 none, 1 wait invalid, 2 wait valid, 3 in frame
    int               cap_state = 0;
    logic [BLK_W-1:0] cap_blk;
    logic [OFS_W:0]   cap_cnt;

    logic             reading = 1'b0;
    logic [BLK_W-1:0] rd_blk;
    logic [OFS_W:0]   rd_cnt;
    logic [`WORD_WIDTH-1:0] expected;

    logic             prev_ready = 1'b0;
    logic             prev_consume = 1'b0;
    logic [`WORD_WIDTH-1:0] prev_data;

    logic abort_pending = 1'b0;
    int   abort_cnt;

    initial begin
        errors     = 0;
        reads_done = 0;
        for (int b = 0; b < `BLOCK_COUNT; b++) begin
            block_valid[b] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            // ==============================
            // Command and abort tracking
            // ==============================
            if (cmd_abort) begin
                cap_state     = 0;
                reading       = 1'b0;
                abort_pending = 1'b1;
                abort_cnt     = 0;
            end else if (abort_pending) begin
                abort_cnt++;
                if (cmd_ready) begin
                    abort_pending = 1'b0;
                    if (readout_ready) begin
                        $display("Error at %0t: readout_ready still high after abort", $time);
                        errors++;
                    end
                end else if (abort_cnt >= 3) begin
                    $display("Error at %0t: cmd_ready not back within three cycles of abort",
                             $time);
                    errors++;
                    abort_pending = 1'b0;
                end
            end else if (cmd_ready && cmd_trigger) begin
                if (cmd == pix_pkg::CMD_CAPTURE) begin
                    // A running frame is skipped
                    cap_state = pix_fv ? 1 : 2;
                    cap_blk   = cmd_block;
                    cap_cnt   = '0;
                    block_valid[cmd_block] = 1'b0;
                end else begin
                    reading = 1'b1;
                    rd_blk  = cmd_block;
                    rd_cnt  = '0;
                    if (!block_valid[cmd_block]) begin
                        $display("Error at %0t: readout of block %0d with no stored frame",
                                 $time, cmd_block);
                        errors++;
                    end
                end
            end else if (reading && cmd_ready) begin
                reading = 1'b0;
                if (rd_cnt != (OFS_W + 1)'(`IMAGE_SIZE)) begin
                    $display("Error at %0t: readout returned %0d words instead of %0d",
                             $time, rd_cnt, `IMAGE_SIZE);
                    errors++;
                end else begin
                    reads_done++;
                end
            end

            // ==============================
            // Frame capture from the pins
            // ==============================
            if (cap_state == 1 && !pix_fv) begin
                cap_state = 2;
            end else if (cap_state == 2 && pix_fv) begin
                cap_state = 3;
            end else if (cap_state == 3 && !pix_fv) begin
                $display("Error at %0t: frame ended after %0d pixels", $time, cap_cnt);
                errors++;
                cap_state = 0;
            end
            if (cap_state == 3 && pix_fv && pix_lv) begin
                frame_buf[cap_cnt[OFS_W-1:0]] = pix_d;
                cap_cnt++;
                if (cap_cnt == (OFS_W + 1)'(`IMAGE_SIZE)) begin
                    for (int i = 0; i < `IMAGE_SIZE; i++) begin
                        model[cap_blk][i] = frame_buf[i];
                    end
                    block_valid[cap_blk] = 1'b1;
                    cap_state = 0;
                end
            end

            // Holding register must not move under back-pressure
            if (readout_ready && prev_ready && !prev_consume && readout_data != prev_data) begin
                $display("Fail at %0t: readout_data expected %h, got %h",
                         $time, prev_data, readout_data);
                errors++;
            end

            if (reading && readout_ready && readout_trigger) begin
                expected = `WORD_WIDTH'(model[rd_blk][rd_cnt[OFS_W-1:0]]);
                if (readout_data != expected) begin
                    $display("Fail at %0t: readout_data expected %h, got %h",
                             $time, expected, readout_data);
                    errors++;
                end
                rd_cnt++;
            end
        end
        prev_ready   = readout_ready;
        prev_consume = readout_ready && readout_trigger;
        prev_data    = readout_data;
    end

endmodule

// File: hw/pix_top.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module pix_top (
    input  logic                             clk,
    input  logic                             rst,
    // Command port
    output logic                             cmd_ready,
    input  logic                             cmd_trigger,
    input  pix_pkg::pix_cmd_t                cmd,
    input  logic [$clog2(`BLOCK_COUNT)-1:0]  cmd_block,
    input  logic                             cmd_abort,
    // Readout port
    output logic                             readout_ready,
    input  logic                             readout_trigger,
    output logic [`WORD_WIDTH-1:0]           readout_data,
    // Pixel port
    input  logic [`PIX_WIDTH-1:0]            pix_d,
    input  logic                             pix_fv,
    input  logic                             pix_lv
);

    // Input side
    logic                   arm;
    logic                   flush;
    logic                   pixel_valid;
    logic [`WORD_WIDTH-1:0] pixel_data;
    logic                   fifo_empty;
    logic [`WORD_WIDTH-1:0] fifo_data;
    logic                   fifo_pop;

    // Controller to frame store
    logic                             store_cmd_ready;
    logic                             store_cmd_trigger;
    logic                             store_cmd_write;
    logic [$clog2(`BLOCK_COUNT)-1:0]  store_cmd_block;
    logic                             store_abort;
    logic                             store_write_ready;
    logic                             store_write_trigger;
    logic [`WORD_WIDTH-1:0]           store_write_data;

    pix_frame_sync sync_i (
        .clk         (clk),
        .rst         (rst),
        .arm         (arm),
        .flush       (flush),
        .pix_d       (pix_d),
        .pix_fv      (pix_fv),
        .pix_lv      (pix_lv),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data)
    );

    pix_fifo fifo_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (pixel_valid),
        .push_data  (pixel_data),
        .pop        (fifo_pop),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data)
    );

    pix_controller ctrl_i (
        .clk                 (clk),
        .rst                 (rst),
        .cmd_ready           (cmd_ready),
        .cmd_trigger         (cmd_trigger),
        .cmd                 (cmd),
        .cmd_block           (cmd_block),
        .cmd_abort           (cmd_abort),
        .arm                 (arm),
        .flush               (flush),
        .fifo_empty          (fifo_empty),
        .fifo_data           (fifo_data),
        .fifo_pop            (fifo_pop),
        .store_cmd_ready     (store_cmd_ready),
        .store_cmd_trigger   (store_cmd_trigger),
        .store_cmd_write     (store_cmd_write),
        .store_cmd_block     (store_cmd_block),
        .store_abort         (store_abort),
        .store_write_ready   (store_write_ready),
        .store_write_trigger (store_write_trigger),
        .store_write_data    (store_write_data)
    );

    frame_store store_i (
        .clk                 (clk),
        .rst                 (rst),
        .store_cmd_ready     (store_cmd_ready),
        .store_cmd_trigger   (store_cmd_trigger),
        .store_cmd_write     (store_cmd_write),
        .store_cmd_block     (store_cmd_block),
        .store_abort         (store_abort),
        .store_write_ready   (store_write_ready),
        .store_write_trigger (store_write_trigger),
        .store_write_data    (store_write_data),
        .readout_ready       (readout_ready),
        .readout_trigger     (readout_trigger),
        .readout_data        (readout_data)
    );

endmodule

// File: hw/frame_store.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module frame_store (
    input  logic                             clk,
    input  logic                             rst,
    // Command port
    output logic                             store_cmd_ready,
    input  logic                             store_cmd_trigger,
    input  logic                             store_cmd_write,
    input  logic [$clog2(`BLOCK_COUNT)-1:0]  store_cmd_block,
    input  logic                             store_abort,
    // Write port
    output logic                             store_write_ready,
    input  logic                             store_write_trigger,
    input  logic [`WORD_WIDTH-1:0]           store_write_data,
    // Readout port
    output logic                             readout_ready,
    input  logic                             readout_trigger,
    output logic [`WORD_WIDTH-1:0]           readout_data
);

    localparam int BLK_W = $clog2(`BLOCK_COUNT);
    localparam int OFS_W = $clog2(`IMAGE_SIZE);
    localparam int CNT_W = OFS_W + 1;

    pix_pkg::store_state_t state;

    logic [`WORD_WIDTH-1:0] mem [`BLOCK_COUNT * `IMAGE_SIZE];
    logic [BLK_W-1:0]       block;
    // Words written, or words fetched, in the current command
    logic [CNT_W-1:0]       count;
    logic [BLK_W+OFS_W-1:0] addr;
    logic                   mem_we;
    logic                   consume;
    logic                   fetch;

    assign store_cmd_ready   = (state == pix_pkg::STORE_IDLE);
    assign store_write_ready = (state == pix_pkg::STORE_WRITING);

    assign addr    = {block, count[OFS_W-1:0]};
    assign mem_we  = (state == pix_pkg::STORE_WRITING) && store_write_trigger;
    assign consume = readout_ready && readout_trigger;
    // Fetch ahead when the holding register is empty or being emptied
    assign fetch   = (state == pix_pkg::STORE_READING) && (count != CNT_W'(`IMAGE_SIZE))
                     && (!readout_ready || consume);

    // ==============================
    // Memory and holding register
    // ==============================
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[addr] <= store_write_data;
        end
        if (fetch) begin
            readout_data <= mem[addr];
        end
    end

    // ==============================
    // Command sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= pix_pkg::STORE_IDLE;
            block         <= '0;
            count         <= '0;
            readout_ready <= 1'b0;
        end else if (store_abort) begin
            state         <= pix_pkg::STORE_IDLE;
            readout_ready <= 1'b0;
        end else begin
            case (state)
                pix_pkg::STORE_IDLE: begin
                    if (store_cmd_trigger) begin
                        block <= store_cmd_block;
                        count <= '0;
                        state <= store_cmd_write ? pix_pkg::STORE_WRITING
                                                 : pix_pkg::STORE_READING;
                    end
                end
                pix_pkg::STORE_WRITING: begin
                    if (mem_we) begin
                        count <= count + 1'b1;
                        if (count == CNT_W'(`IMAGE_SIZE - 1)) begin
                            state <= pix_pkg::STORE_IDLE;
                        end
                    end
                end
                pix_pkg::STORE_READING: begin
                    if (fetch) begin
                        count         <= count + 1'b1;
                        readout_ready <= 1'b1;
                    end else if (consume) begin
                        readout_ready <= 1'b0;
                        // Last word handed over
                        if (count == CNT_W'(`IMAGE_SIZE)) begin
                            state <= pix_pkg::STORE_IDLE;
                        end
                    end
                end
                default: state <= pix_pkg::STORE_IDLE;
            endcase
        end
    end

    a_count_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= CNT_W'(`IMAGE_SIZE)
    ) else $error("frame store word counter past image size");

endmodule

// File: hw/pix_controller.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module pix_controller (
    input  logic                             clk,
    input  logic                             rst,
    // Command port
    output logic                             cmd_ready,
    input  logic                             cmd_trigger,
    input  pix_pkg::pix_cmd_t                cmd,
    input  logic [$clog2(`BLOCK_COUNT)-1:0]  cmd_block,
    input  logic                             cmd_abort,
    // Input side
    output logic                             arm,
    output logic                             flush,
    input  logic                             fifo_empty,
    input  logic [`WORD_WIDTH-1:0]           fifo_data,
    output logic                             fifo_pop,
    // Frame store
    input  logic                             store_cmd_ready,
    output logic                             store_cmd_trigger,
    output logic                             store_cmd_write,
    output logic [$clog2(`BLOCK_COUNT)-1:0]  store_cmd_block,
    output logic                             store_abort,
    input  logic                             store_write_ready,
    output logic                             store_write_trigger,
    output logic [`WORD_WIDTH-1:0]           store_write_data
);

    pix_pkg::ctrl_state_t state;
    logic                 cmd_take;

    assign cmd_take = cmd_ready && cmd_trigger;

    // One word per cycle from FIFO to store while both can move
    assign fifo_pop = (state == pix_pkg::CTRL_CAPTURE_COPY) && !fifo_empty && store_write_ready;

    // ==============================
    // Command FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= pix_pkg::CTRL_IDLE;
            cmd_ready           <= 1'b0;
            arm                 <= 1'b0;
            flush               <= 1'b0;
            store_cmd_trigger   <= 1'b0;
            store_abort         <= 1'b0;
            store_write_trigger <= 1'b0;
        end else begin
            arm                 <= 1'b0;
            flush               <= 1'b0;
            store_abort         <= 1'b0;
            store_write_trigger <= fifo_pop;

            case (state)
                pix_pkg::CTRL_IDLE: begin
                    if (cmd_take) begin
                        cmd_ready         <= 1'b0;
                        store_cmd_trigger <= 1'b1;
                        state <= (cmd == pix_pkg::CMD_CAPTURE) ? pix_pkg::CTRL_CAPTURE_CMD
                                                                : pix_pkg::CTRL_READOUT_CMD;
                    end else begin
                        cmd_ready <= 1'b1;
                    end
                end
                pix_pkg::CTRL_CAPTURE_CMD: begin
                    // Store accepted, start looking for a frame
                    if (store_cmd_ready) begin
                        store_cmd_trigger <= 1'b0;
                        arm               <= 1'b1;
                        state             <= pix_pkg::CTRL_CAPTURE_COPY;
                    end
                end
                pix_pkg::CTRL_CAPTURE_COPY: begin
                    // Store goes idle after a full image, drop surplus pixels
                    if (store_cmd_ready) begin
                        flush     <= 1'b1;
                        cmd_ready <= 1'b1;
                        state     <= pix_pkg::CTRL_IDLE;
                    end
                end
                pix_pkg::CTRL_READOUT_CMD: begin
                    if (store_cmd_ready) begin
                        store_cmd_trigger <= 1'b0;
                        state             <= pix_pkg::CTRL_READOUT_WAIT;
                    end
                end
                pix_pkg::CTRL_READOUT_WAIT: begin
                    if (store_cmd_ready) begin
                        cmd_ready <= 1'b1;
                        state     <= pix_pkg::CTRL_IDLE;
                    end
                end
                pix_pkg::CTRL_ABORT: begin
                    // Store is idle by now
                    cmd_ready <= 1'b1;
                    state     <= pix_pkg::CTRL_IDLE;
                end
                default: state <= pix_pkg::CTRL_IDLE;
            endcase

            // Abort overrides whatever is in progress
            if (cmd_abort) begin
                cmd_ready           <= 1'b0;
                arm                 <= 1'b0;
                flush               <= 1'b1;
                store_abort         <= 1'b1;
                store_cmd_trigger   <= 1'b0;
                store_write_trigger <= 1'b0;
                state               <= pix_pkg::CTRL_ABORT;
            end
        end
    end

    // Command fields and write word
    always_ff @(posedge clk) begin
        if (state == pix_pkg::CTRL_IDLE && cmd_take) begin
            store_cmd_write <= (cmd == pix_pkg::CMD_CAPTURE);
            store_cmd_block <= cmd_block;
        end
        if (fifo_pop) begin
            store_write_data <= fifo_data;
        end
    end

    a_no_trigger_idle: assert property (
        @(posedge clk) disable iff (rst)
        state == pix_pkg::CTRL_IDLE |-> !store_cmd_trigger
    ) else $error("store command pending while controller idle");

endmodule

// File: hw/pix_fifo.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module pix_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   push,
    input  logic [`WORD_WIDTH-1:0] push_data,
    input  logic                   pop,
    output logic                   fifo_empty,
    output logic [`WORD_WIDTH-1:0] fifo_data
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [`WORD_WIDTH-1:0] mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    assign fifo_empty = (count == '0);
    // Head word, readable the cycle after it is written
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ==============================
    // Pointers and fill count
    // ==============================
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push && !flush |-> count != CNT_W'(`FIFO_DEPTH)
    ) else $error("push into a full FIFO");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !fifo_empty
    ) else $error("pop from an empty FIFO");

endmodule

// File: hw/pix_frame_sync.sv
`timescale 1ns/10ps
`include "pix_macros.svh"

module pix_frame_sync (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   arm,
    input  logic                   flush,
    input  logic [`PIX_WIDTH-1:0]  pix_d,
    input  logic                   pix_fv,
    input  logic                   pix_lv,
    output logic                   pixel_valid,
    output logic [`WORD_WIDTH-1:0] pixel_data
);

    pix_pkg::sync_state_t state;

    // ==============================
    // Frame tracking
    // ==============================
    // State and strobe are registered together from the pins,
    // giving one cycle from pin to strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= pix_pkg::SYNC_IDLE;
            pixel_valid <= 1'b0;
        end else if (flush) begin
            state       <= pix_pkg::SYNC_IDLE;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= 1'b0;
            case (state)
                pix_pkg::SYNC_IDLE: begin
                    // A frame already running must end first
                    if (arm) begin
                        state <= pix_fv ? pix_pkg::SYNC_WAIT_INVALID : pix_pkg::SYNC_WAIT_VALID;
                    end
                end
                pix_pkg::SYNC_WAIT_INVALID: begin
                    if (!pix_fv) begin
                        state <= pix_pkg::SYNC_WAIT_VALID;
                    end
                end
                pix_pkg::SYNC_WAIT_VALID: begin
                    if (pix_fv) begin
                        state       <= pix_pkg::SYNC_IN_FRAME;
                        pixel_valid <= pix_lv;
                    end
                end
                pix_pkg::SYNC_IN_FRAME: begin
                    // One frame per arm
                    if (!pix_fv) begin
                        state <= pix_pkg::SYNC_IDLE;
                    end else begin
                        pixel_valid <= pix_lv;
                    end
                end
                default: state <= pix_pkg::SYNC_IDLE;
            endcase
        end
    end

    // Pin data register, zero-extended to the stored word
    always_ff @(posedge clk) begin
        pixel_data <= {{(`WORD_WIDTH - `PIX_WIDTH){1'b0}}, pix_d};
    end

    a_valid_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        pixel_valid |-> state == pix_pkg::SYNC_IN_FRAME
    ) else $error("pixel_valid outside a captured frame");

endmodule

// File: hw/pix_pkg.sv
package pix_pkg;

    // Command codes on the command port
    typedef enum logic {
        CMD_CAPTURE = 1'b0,
        CMD_READOUT = 1'b1
    } pix_cmd_t;

    // Command controller
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_CAPTURE_CMD,
        CTRL_CAPTURE_COPY,
        CTRL_READOUT_CMD,
        CTRL_READOUT_WAIT,
        CTRL_ABORT
    } ctrl_state_t;

    // Frame synchronizer
    typedef enum logic [1:0] {
        SYNC_IDLE,
        SYNC_WAIT_INVALID,
        SYNC_WAIT_VALID,
        SYNC_IN_FRAME
    } sync_state_t;

    // Frame store sequencing
    typedef enum logic [1:0] {
        STORE_IDLE,
        STORE_WRITING,
        STORE_READING
    } store_state_t;

endpackage

// File: include/pix_macros.svh
`ifndef PIX_MACROS_SVH
`define PIX_MACROS_SVH

// Sensor pixel and stored word widths
`define PIX_WIDTH 12
`define WORD_WIDTH 16

// Words per frame and per store block (16 by 16 frame)
`define IMAGE_SIZE 256

// Frame store blocks, 3-bit block index
`define BLOCK_COUNT 8

// Entries in the capture FIFO
`define FIFO_DEPTH 16

`endif
